// ==== source/rename_pkg.sv ====
// Shared sizes and tag types for the rename free-list
// Every RTL file imports this package and pulls in only what it needs
// A physical register tag is one 6-bit word that is read either as a
// flat register number or as a bank and slot pair

package rename_pkg;

	// ==========================================================
	// Register file geometry
	// ==========================================================

	// Total physical registers tracked by the availability map
	localparam int num_pregs = 64;

	// One bank per rename lane
	localparam int num_banks = 4;

	// Registers held by each bank
	localparam int bank_size = num_pregs / num_banks;

	// ==========================================================
	// Tag types
	// ==========================================================

	// Register index inside one bank
	typedef logic [$clog2(bank_size)-1:0] slot_t;

	// Bank number, which is also the lane that owns the bank
	typedef logic [$clog2(num_banks)-1:0] bank_t;

	// Split view of a tag, bank in the upper bits
	typedef struct packed {
		bank_t bank;
		slot_t slot;
	} preg_fields_t;

	// The flat view indexes the map and the split view feeds the banks
	typedef union packed {
		logic [$clog2(num_pregs)-1:0] flat;
		preg_fields_t                 f;
	} preg_t;

endpackage

// ==== source/free_list_scanner.sv ====
// Bulk-free drain for one bank
// Holds one pending bit per slot of the bank and offers the lowest
// pending slot every enabled cycle; the bank takes it when the lane
// has no direct free, and the bit clears at the following edge

module free_list_scanner (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              en,
	input  logic [rename_pkg::bank_size-1:0] bulk_free,
	input  logic                              take,
	output logic                              scan_valid,
	output rename_pkg::slot_t                 scan_slot
);
	import rename_pkg::*;

	// Slots that were freed in bulk and are not yet in the FIFO
	logic [bank_size-1:0] pending;

	// One-hot of the slot handed to the bank this cycle
	logic [bank_size-1:0] take_mask;

	// Nothing is offered while the core is frozen
	assign scan_valid = en & (|pending);

	// Lowest set bit wins, so the drain runs in ascending slot order
	always_comb begin
		scan_slot = '0;
		for (int i = bank_size - 1; i >= 0; i--) begin
			if (pending[i])
				scan_slot = slot_t'(i);
		end
	end

	assign take_mask = {{(bank_size - 1){1'b0}}, take} << scan_slot;

	// Reset marks every slot pending so the bank fills itself
	// New bulk frees merge in and the taken slot drops out
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '1;
		end
		else if (en) begin
			pending <= (pending | bulk_free) & ~take_mask;
		end
	end

endmodule

// ==== source/free_tag_fifo.sv ====
// Circular FIFO of free slot numbers for one bank
// The head entry is the next tag handed out when the lane has neither
// a direct free nor a scanned slot to bypass
// Push and pop may happen in the same cycle; the depth equals the bank
// size, and since each slot lives in one place only it cannot overflow

module free_tag_fifo (
	input  logic              clk,
	input  logic              rst,
	input  logic              en,
	input  logic              push,
	input  rename_pkg::slot_t push_slot,
	input  logic              pop,
	output rename_pkg::slot_t head_slot,
	output logic              empty
);
	import rename_pkg::*;

	// ==========================================================
	// Storage and pointers
	// ==========================================================

	// Entry storage, one slot number per entry
	slot_t mem [bank_size];

	// Pointers wrap naturally since the depth is a power of two
	slot_t wr_ptr;
	slot_t rd_ptr;

	// Occupancy needs one extra bit to hold a full count
	logic [$clog2(bank_size + 1)-1:0] count;

	// Qualified strobes; a pop on an empty FIFO is dropped
	logic do_push;
	logic do_pop;

	assign do_push = en & push;
	assign do_pop  = en & pop & ~empty;

	assign empty     = (count == '0);
	assign head_slot = mem[rd_ptr];

	// ==========================================================
	// Update
	// ==========================================================

	// Each accepted push writes its slot at the tail pointer
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_slot;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count unchanged
			if (do_push & ~do_pop)
				count <= count + 1'b1;
			else if (do_pop & ~do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== source/rename_bank.sv ====
// One rename lane and its bank of physical registers
// Picks the lane's tag from a direct free, then a scanned slot, then the
// FIFO head, and reports to the tracker which register became free or
// was allocated; the lane index comes from the top-level generate loop

module rename_bank #(
	parameter int lane = 0
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              en,
	input  logic                              alloc_go,
	input  logic                              free_valid,
	input  rename_pkg::preg_t                 free_tag,
	input  logic [rename_pkg::bank_size-1:0] bulk_free,
	output rename_pkg::preg_t                 alloc_tag,
	output logic                              bank_stall,
	output logic                              set_valid,
	output rename_pkg::preg_t                 set_tag,
	output logic                              clr_valid,
	output rename_pkg::preg_t                 clr_tag
);
	import rename_pkg::*;

	logic  scan_valid;
	slot_t scan_slot;
	slot_t head_slot;
	logic  empty;
	logic  take;
	logic  push;
	logic  pop;

	// Slot that arrives this cycle from a free or from the scan
	slot_t new_slot;

	// ==========================================================
	// Source selection
	// ==========================================================

	// A direct free always beats the scan, which then waits a cycle
	assign take     = scan_valid & ~free_valid;
	assign new_slot = free_valid ? free_tag.f.slot : scan_slot;

	// Without an arriving slot, the FIFO must supply one
	assign bank_stall = empty & ~free_valid & ~scan_valid;

	// Arriving slot goes to the FIFO unless the lane takes it directly
	assign push = (free_valid | scan_valid) & ~alloc_go;
	assign pop  = alloc_go & ~free_valid & ~scan_valid;

	// Tags are rebuilt from slots with this lane's bank number
	always_comb begin
		alloc_tag.f.bank = bank_t'(lane);
		alloc_tag.f.slot = (free_valid | scan_valid) ? new_slot : head_slot;
		set_tag.f.bank   = bank_t'(lane);
		set_tag.f.slot   = new_slot;
		clr_tag.f.bank   = bank_t'(lane);
		clr_tag.f.slot   = head_slot;
	end

	// A bypassed tag was never marked free, so the map needs no action
	assign set_valid = push;
	assign clr_valid = pop;

	// ==========================================================
	// Scanner and FIFO
	// ==========================================================

	free_list_scanner i_scanner (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.bulk_free  (bulk_free),
		.take       (take),
		.scan_valid (scan_valid),
		.scan_slot  (scan_slot)
	);

	free_tag_fifo i_fifo (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.push      (push),
		.push_slot (new_slot),
		.pop       (pop),
		.head_slot (head_slot),
		.empty     (empty)
	);

endmodule

// ==== source/avail_tracker.sv ====
// Availability map and global stall for the rename stage
// Collects the per-bank stall levels into one stall, gates the lane
// allocate strobes with it, and keeps one bit per physical register
// that the reorder buffer reads to see which registers are free

module avail_tracker (
	input  logic                                              clk,
	input  logic                                              rst,
	input  logic                                              en,
	input  logic [rename_pkg::num_banks-1:0]                 alloc,
	input  logic [rename_pkg::num_banks-1:0]                 bank_stall,
	input  logic [rename_pkg::num_banks-1:0]                 set_valid,
	input  rename_pkg::preg_t [rename_pkg::num_banks-1:0]    set_tag,
	input  logic [rename_pkg::num_banks-1:0]                 clr_valid,
	input  rename_pkg::preg_t [rename_pkg::num_banks-1:0]    clr_tag,
	output logic [rename_pkg::num_banks-1:0]                 alloc_go,
	output logic                                              stall,
	output logic [rename_pkg::num_pregs-1:0]                 avail
);
	import rename_pkg::*;

	// ==========================================================
	// Stall and allocate gating
	// ==========================================================

	// One empty bank holds back every lane so the group stays in order
	assign stall = |bank_stall;

	// While stalled all allocs are dropped; frees and scans still run
	assign alloc_go = alloc & {num_banks{~stall}};

	// ==========================================================
	// Map update
	// ==========================================================

	// Each lane owns its own bank, so the set and clear indexes of
	// different lanes never collide within one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			avail <= '0;
		end
		else if (en) begin
			for (int i = 0; i < num_banks; i++) begin
				// Register entered the FIFO and is now free
				if (set_valid[i])
					avail[set_tag[i].flat] <= 1'b1;
				// Register popped from the FIFO for allocation
				if (clr_valid[i])
					avail[clr_tag[i].flat] <= 1'b0;
			end
		end
	end

endmodule

// ==== source/reg_renamer.sv ====
// Physical register free-list for the rename stage
// Four lanes, each bound to one bank of sixteen registers, allocate and
// free one tag per cycle; bulk_free returns many registers after a flush
// avail and stall go to the reorder buffer and the dispatch logic

module reg_renamer (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           en,
	input  logic [rename_pkg::num_banks-1:0]              alloc,
	input  logic [rename_pkg::num_banks-1:0]              free_valid,
	input  rename_pkg::preg_t [rename_pkg::num_banks-1:0] free_tags,
	input  logic [rename_pkg::num_pregs-1:0]              bulk_free,
	output rename_pkg::preg_t [rename_pkg::num_banks-1:0] alloc_tags,
	output logic [rename_pkg::num_pregs-1:0]              avail,
	output logic                                           stall
);
	import rename_pkg::*;

	logic  [num_banks-1:0] alloc_go;
	logic  [num_banks-1:0] bank_stall;
	logic  [num_banks-1:0] set_valid;
	preg_t [num_banks-1:0] set_tag;
	logic  [num_banks-1:0] clr_valid;
	preg_t [num_banks-1:0] clr_tag;

	// ==========================================================
	// Banks, one per lane
	// ==========================================================

	// Bulk-free bit n lands in bank n / bank_size, slot n % bank_size
	for (genvar i = 0; i < num_banks; i++) begin : g_bank
		rename_bank #(
			.lane (i)
		) i_bank (
			.clk        (clk),
			.rst        (rst),
			.en         (en),
			.alloc_go   (alloc_go[i]),
			.free_valid (free_valid[i]),
			.free_tag   (free_tags[i]),
			.bulk_free  (bulk_free[i*bank_size +: bank_size]),
			.alloc_tag  (alloc_tags[i]),
			.bank_stall (bank_stall[i]),
			.set_valid  (set_valid[i]),
			.set_tag    (set_tag[i]),
			.clr_valid  (clr_valid[i]),
			.clr_tag    (clr_tag[i])
		);
	end

	avail_tracker i_tracker (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.alloc      (alloc),
		.bank_stall (bank_stall),
		.set_valid  (set_valid),
		.set_tag    (set_tag),
		.clr_valid  (clr_valid),
		.clr_tag    (clr_tag),
		.alloc_go   (alloc_go),
		.stall      (stall),
		.avail      (avail)
	);

endmodule

// ==== tests/reg_renamer_assertions.sv ====
// Concurrent checks on the rename free-list top level
// Bound to every reg_renamer instance; watches the lane free tags, the
// FIFO pops and the availability map

module reg_renamer_assertions (
	input logic                                           clk,
	input logic                                           rst,
	input logic                                           en,
	input logic                                           stall,
	input logic [rename_pkg::num_banks-1:0]              free_valid,
	input rename_pkg::preg_t [rename_pkg::num_banks-1:0] free_tags,
	input logic [rename_pkg::num_banks-1:0]              clr_valid,
	input rename_pkg::preg_t [rename_pkg::num_banks-1:0] alloc_tags,
	input logic [rename_pkg::num_pregs-1:0]              avail
);
	import rename_pkg::*;

	// While any bank is dry no register may leave the map at the next edge
	a_no_alloc_in_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> (($past(avail) & ~avail) == '0))
		else $error("A register was allocated while stall was high");

	for (genvar i = 0; i < num_banks; i++) begin : g_lane
		// Each lane returns registers to its own bank only
		a_free_bank: assert property (@(posedge clk) disable iff (rst)
			free_valid[i] |-> (free_tags[i].f.bank == bank_t'(i)))
			else $error("Freed tag on lane %0d names another bank", i);

		// A tag popped from the FIFO must still be marked free in the map
		a_popped_avail: assert property (@(posedge clk) disable iff (rst)
			(en && clr_valid[i]) |-> avail[alloc_tags[i].flat])
			else $error("Lane %0d allocated a tag that the map shows in use", i);
	end

endmodule

bind reg_renamer reg_renamer_assertions i_assertions (
	.clk        (clk),
	.rst        (rst),
	.en         (en),
	.stall      (stall),
	.free_valid (free_valid),
	.free_tags  (free_tags),
	.clr_valid  (clr_valid),
	.alloc_tags (alloc_tags),
	.avail      (avail)
);

// ==== tests/reg_renamer_tb.sv ====
// Testbench for the rename free-list
// Reads one stimulus line per cycle from the pattern file, drives the
// four lanes just after the rising edge and checks the allocated tags,
// the stall level and the population of the availability map at the
// falling edge, while every output is settled

module reg_renamer_tb;
	import rename_pkg::*;

	// ==========================================================
	// Pattern table layout
	// ==========================================================

	// Columns per line and lines in the pattern file
	localparam int num_fields   = 14;
	localparam int num_patterns = 41;

	// Cycle budget for the whole run, reset included
	localparam int timeout_cycles = num_patterns + 20;

	// Column offsets within one line
	localparam int f_en        = 0;
	localparam int f_alloc     = 1;
	localparam int f_free      = 2;
	localparam int f_free_tag  = 3;
	localparam int f_bulk      = 7;
	localparam int f_exp_tag   = 8;
	localparam int f_exp_stall = 12;
	localparam int f_exp_count = 13;

	logic [63:0] patterns [num_fields * num_patterns];

	// DUT ports
	logic                    clk;
	logic                    rst;
	logic                    en;
	logic [num_banks-1:0]    alloc;
	logic [num_banks-1:0]    free_valid;
	preg_t [num_banks-1:0]   free_tags;
	logic [num_pregs-1:0]    bulk_free;
	preg_t [num_banks-1:0]   alloc_tags;
	logic [num_pregs-1:0]    avail;
	logic                    stall;

	int errors;
	int checks;
	int cycle_count;

	reg_renamer i_reg_renamer (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.alloc      (alloc),
		.free_valid (free_valid),
		.free_tags  (free_tags),
		.bulk_free  (bulk_free),
		.alloc_tags (alloc_tags),
		.avail      (avail),
		.stall      (stall)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ends a run that stops making progress
	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	// ==========================================================
	// Helpers
	// ==========================================================

	// Number of registers the map currently shows as free
	function automatic int count_avail(input logic [num_pregs-1:0] map);
		int n;
		n = 0;
		for (int i = 0; i < num_pregs; i++) begin
			if (map[i] === 1'b1)
				n++;
		end
		return n;
	endfunction

	// Puts one pattern line on the DUT inputs
	task automatic apply_pattern(input int k);
		int base;
		base       = k * num_fields;
		en         = patterns[base + f_en][0];
		alloc      = patterns[base + f_alloc][num_banks-1:0];
		free_valid = patterns[base + f_free][num_banks-1:0];
		for (int i = 0; i < num_banks; i++) begin
			free_tags[i].flat = patterns[base + f_free_tag + i][5:0];
		end
		bulk_free = patterns[base + f_bulk];
	endtask

	// Compares stall, map population and the tags of allocating lanes
	task automatic check_outputs(input int k);
		int         base;
		int         exp_count;
		int         got_count;
		logic       exp_stall;
		logic [5:0] exp_tag;
		base      = k * num_fields;
		exp_stall = patterns[base + f_exp_stall][0];
		exp_count = int'(patterns[base + f_exp_count]);
		got_count = count_avail(avail);
		checks    = checks + 2;
		if (stall !== exp_stall) begin
			errors++;
			$display("Mismatch at %0t: pattern %0d stall %b, expected %b",
				$time, k, stall, exp_stall);
		end
		if (got_count != exp_count) begin
			errors++;
			$display("Mismatch at %0t: pattern %0d avail holds %0d free, expected %0d",
				$time, k, got_count, exp_count);
		end
		// A lane's tag only means something when it really allocates
		for (int i = 0; i < num_banks; i++) begin
			if (alloc[i] && !exp_stall) begin
				exp_tag = patterns[base + f_exp_tag + i][5:0];
				checks++;
				if (alloc_tags[i].flat !== exp_tag) begin
					errors++;
					$display("Mismatch at %0t: pattern %0d lane %0d tag %h, expected %h",
						$time, k, i, alloc_tags[i].flat, exp_tag);
				end
			end
		end
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		errors     = 0;
		checks     = 0;
		rst        = 1'b1;
		en         = 1'b0;
		alloc      = '0;
		free_valid = '0;
		free_tags  = '0;
		bulk_free  = '0;
		$readmemh("tests/rename_patterns.txt", patterns);
		if ($isunknown(patterns[num_fields * num_patterns - 1])) begin
			errors++;
			$display("The pattern file is missing or shorter than expected");
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		// Inputs change 1 unit after the edge, outputs are read mid cycle
		for (int k = 0; k < num_patterns; k++) begin
			apply_pattern(k);
			@(negedge clk);
			check_outputs(k);
			@(posedge clk);
			#1;
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
source/rename_pkg.sv
source/free_list_scanner.sv
source/free_tag_fifo.sv
source/rename_bank.sv
source/avail_tracker.sv
source/reg_renamer.sv
tests/reg_renamer_assertions.sv
tests/reg_renamer_tb.sv

// ==== tests/rename_patterns.txt ====
// en alloc free_valid free_tag0..3 bulk_free exp_tag0..3 exp_stall exp_avail_count
// All hex; exp_avail_count is the map population seen during the line
// Tags are checked only on lanes that allocate while no stall is expected
0 0 0 00 00 00 00 0000000000000000 00 00 00 00 1 00
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 00
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 04
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 08
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 0c
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 10
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 14
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 18
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 1c
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 20
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 24
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 28
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 2c
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 30
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 34
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 38
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 3c
1 f 0 00 00 00 00 0000000000000000 00 10 20 30 0 40
1 f 0 00 00 00 00 0000000000000000 01 11 21 31 0 3c
1 e 1 00 00 00 00 0000000000000000 00 12 22 32 0 38
1 5 4 00 00 20 00 0000000000000000 02 00 20 00 0 36
1 1 2 00 11 00 00 0000000000000000 03 00 00 00 0 35
1 1 0 00 00 00 00 0000000000000000 04 00 00 00 0 35
1 1 0 00 00 00 00 0000000000000000 05 00 00 00 0 34
1 1 0 00 00 00 00 0000000000000000 06 00 00 00 0 33
1 1 0 00 00 00 00 0000000000000000 07 00 00 00 0 32
1 1 0 00 00 00 00 0000000000000000 08 00 00 00 0 31
1 1 0 00 00 00 00 0000000000000000 09 00 00 00 0 30
1 1 0 00 00 00 00 0000000000000000 0a 00 00 00 0 2f
1 1 0 00 00 00 00 0000000000000000 0b 00 00 00 0 2e
1 1 0 00 00 00 00 0000000000000000 0c 00 00 00 0 2d
1 1 0 00 00 00 00 0000000000000000 0d 00 00 00 0 2c
1 1 0 00 00 00 00 0000000000000000 0e 00 00 00 0 2b
1 1 0 00 00 00 00 0000000000000000 0f 00 00 00 0 2a
1 1 0 00 00 00 00 0000000000000000 00 00 00 00 0 29
1 f 0 00 00 00 00 0000000000000000 00 00 00 00 1 28
1 f 0 00 00 00 00 0000000200000228 00 00 00 00 1 28
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 28
1 0 0 00 00 00 00 0000000000000000 00 00 00 00 0 2a
1 1 0 00 00 00 00 0000000000000000 09 00 00 00 0 2b
1 1 0 00 00 00 00 0000000000000000 03 00 00 00 0 2b
